//--- Makefile
# Verilator build and run for the wall clock testbench

VERILATOR ?= verilator
TOP       ?= tb_clock_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hw/clock_pkg.sv
hw/disp_pkg.sv
hw/time_ctrl_if.sv
hw/clock_ctrl.sv
hw/time_keeper.sv
hw/seg_encode.sv
hw/seg_scan.sv
hw/clock_top.sv
testbench/tb_clock_top.sv

//--- hw/clock_ctrl.sv
`timescale 1ns/1ps

module clock_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_btn_mode,
	input  logic                            i_btn_pos,
	input  logic                            i_btn_inc,
	input  logic                            i_btn_alarm,
	time_ctrl_if.ctrl                       o_tc,
	output logic                            o_alarm_en,
	output logic [disp_pkg::NUM_DIGITS-1:0] o_blink_mask
);

	typedef logic [$clog2(clock_pkg::SEC_DIV)-1:0]  sec_cnt_t;
	typedef logic [$clog2(disp_pkg::BLINK_DIV)-1:0] blink_cnt_t;

	logic [3:0]       btn_meta;	// bit 0 mode, 1 pos, 2 inc, 3 alarm
	logic [3:0]       btn_sync;
	logic [3:0]       btn_last;
	logic [3:0]       btn_rise;
	clock_pkg::mode_e mode;
	clock_pkg::pos_e  pos;
	sec_cnt_t         sec_cnt;
	blink_cnt_t       blink_cnt;
	logic             blink_on;
	logic             sec_tick;
	logic             edit_time;
	logic             edit_alarm;

	// ------------------------------
	// buttons
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '0;
			btn_sync <= '0;
			btn_last <= '0;
		end else begin
			btn_meta <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
			btn_sync <= btn_meta;
			btn_last <= btn_sync;
		end
	end

	assign btn_rise = btn_sync & ~btn_last;	// one pulse per press

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode       <= clock_pkg::MODE_CLOCK;
			pos        <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (btn_rise[0]) begin
				case (mode)
					clock_pkg::MODE_CLOCK: mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: mode <= clock_pkg::MODE_ALARM;
					default:               mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (btn_rise[1]) begin
				case (pos)
					clock_pkg::POS_SEC: pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: pos <= clock_pkg::POS_HR;
					default:            pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (btn_rise[3])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// ------------------------------
	// strobes and time bases
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt    <= sec_cnt_t'(clock_pkg::SEC_DIV - 1);
			blink_cnt  <= blink_cnt_t'(disp_pkg::BLINK_DIV - 1);
			blink_on   <= 1'b1;
			sec_tick   <= 1'b0;
			edit_time  <= 1'b0;
			edit_alarm <= 1'b0;
		end else begin
			sec_cnt  <= (sec_cnt == '0) ? sec_cnt_t'(clock_pkg::SEC_DIV - 1) : sec_cnt - 1'b1;
			sec_tick <= (sec_cnt == '0) && (mode != clock_pkg::MODE_SETUP);	// divider keeps running
			if (blink_cnt == '0) begin
				blink_cnt <= blink_cnt_t'(disp_pkg::BLINK_DIV - 1);
				blink_on  <= ~blink_on;
			end else begin
				blink_cnt <= blink_cnt - 1'b1;
			end
			edit_time  <= btn_rise[2] && (mode == clock_pkg::MODE_SETUP);
			edit_alarm <= btn_rise[2] && (mode == clock_pkg::MODE_ALARM);
		end
	end

	assign o_tc.sec_tick   = sec_tick;
	assign o_tc.edit_time  = edit_time;
	assign o_tc.edit_alarm = edit_alarm;
	assign o_tc.pos        = pos;
	assign o_tc.mode       = mode;

	always_comb begin
		o_blink_mask = '1;
		if (mode != clock_pkg::MODE_CLOCK && !blink_on) begin
			case (pos)
				clock_pkg::POS_SEC: o_blink_mask[1:0] = 2'b00;
				clock_pkg::POS_MIN: o_blink_mask[3:2] = 2'b00;
				default:            o_blink_mask[5:4] = 2'b00;
			endcase
		end
	end

	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		mode inside {clock_pkg::MODE_CLOCK, clock_pkg::MODE_SETUP, clock_pkg::MODE_ALARM});

endmodule

//--- hw/clock_pkg.sv
package clock_pkg;

	// ------------------------------
	// modes and edit positions
	// ------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'b00,
		POS_MIN = 2'b01,
		POS_HR  = 2'b10
	} pos_e;

	// ------------------------------
	// time fields
	// ------------------------------
	localparam int FIELD_W = 6;

	localparam logic [FIELD_W-1:0] SEC_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] HR_MAX  = 6'd23;	// 24h only

	typedef struct packed {
		logic [FIELD_W-1:0] hr;
		logic [FIELD_W-1:0] min;
		logic [FIELD_W-1:0] sec;
	} hms_t;

	localparam int SEC_DIV = 100;	// sim value, board uses the clk rate

endpackage

//--- hw/clock_top.sv
`timescale 1ns/1ps

module clock_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            i_btn_mode,
	input  logic                            i_btn_pos,
	input  logic                            i_btn_inc,
	input  logic                            i_btn_alarm,
	output disp_pkg::seg_t                  o_seg,
	output logic [disp_pkg::NUM_DIGITS-1:0] o_seg_enb,
	output logic                            o_alarm
);

	clock_pkg::hms_t                  disp;
	logic                             alarm_en;
	logic [disp_pkg::NUM_DIGITS-1:0]  blink_mask;
	disp_pkg::seg_t                   digit_seg [disp_pkg::NUM_DIGITS];

	time_ctrl_if u_tc ();

	clock_ctrl u_clock_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_btn_mode   (i_btn_mode),
		.i_btn_pos    (i_btn_pos),
		.i_btn_inc    (i_btn_inc),
		.i_btn_alarm  (i_btn_alarm),
		.o_tc         (u_tc.ctrl),
		.o_alarm_en   (alarm_en),
		.o_blink_mask (blink_mask)
	);

	time_keeper u_time_keeper (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_alarm_en (alarm_en),
		.i_tc       (u_tc.keeper),
		.o_disp     (disp),
		.o_alarm    (o_alarm)
	);

	// ------------------------------
	// display path
	// ------------------------------
	seg_encode u_seg_encode (
		.i_disp       (disp),
		.i_blink_mask (blink_mask),
		.o_digit_seg  (digit_seg)
	);

	seg_scan u_seg_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_digit_seg (digit_seg),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

//--- hw/disp_pkg.sv
package disp_pkg;

	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

	// {a, b, c, d, e, f, g}, 1 = lit
	typedef logic [SEG_W-1:0] seg_t;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// ------------------------------
	// digit codes 0..9
	// ------------------------------
	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110,
		7'b011_0000,
		7'b110_1101,
		7'b111_1001,
		7'b011_0011,
		7'b101_1011,
		7'b101_1111,
		7'b111_0000,
		7'b111_1111,
		7'b111_0011
	};

	localparam int SCAN_DIV  = 4;	// clk cycles per digit
	localparam int BLINK_DIV = 48;	// clk cycles per blink half period

endpackage

//--- hw/seg_encode.sv
`timescale 1ns/1ps

module seg_encode (
	input  clock_pkg::hms_t                 i_disp,
	input  logic [disp_pkg::NUM_DIGITS-1:0] i_blink_mask,
	output disp_pkg::seg_t                  o_digit_seg [disp_pkg::NUM_DIGITS]
);

	logic [3:0] num [disp_pkg::NUM_DIGITS];

	// ------------------------------
	// field split, ones on even digits
	// ------------------------------
	always_comb begin
		num[0] = 4'(i_disp.sec % 10);
		num[1] = 4'(i_disp.sec / 10);
		num[2] = 4'(i_disp.min % 10);
		num[3] = 4'(i_disp.min / 10);
		num[4] = 4'(i_disp.hr % 10);
		num[5] = 4'(i_disp.hr / 10);
	end

	always_comb begin
		for (int d = 0; d < disp_pkg::NUM_DIGITS; d++) begin
			if (!i_blink_mask[d]) begin
				o_digit_seg[d] = disp_pkg::SEG_BLANK;	// blink off phase
			end else begin
				o_digit_seg[d] = disp_pkg::SEG_DIGIT[num[d]];
			end
		end
	end

endmodule

//--- hw/seg_scan.sv
`timescale 1ns/1ps

module seg_scan (
	input  logic                            clk,
	input  logic                            rst_n,
	input  disp_pkg::seg_t                  i_digit_seg [disp_pkg::NUM_DIGITS],
	output disp_pkg::seg_t                  o_seg,
	output logic [disp_pkg::NUM_DIGITS-1:0] o_seg_enb
);

	typedef logic [$clog2(disp_pkg::SCAN_DIV)-1:0]   scan_cnt_t;
	typedef logic [$clog2(disp_pkg::NUM_DIGITS)-1:0] ptr_t;

	scan_cnt_t scan_cnt;
	ptr_t      ptr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= scan_cnt_t'(disp_pkg::SCAN_DIV - 1);
			ptr      <= '0;
		end else if (scan_cnt == '0) begin
			scan_cnt <= scan_cnt_t'(disp_pkg::SCAN_DIV - 1);
			ptr      <= (ptr >= ptr_t'(disp_pkg::NUM_DIGITS - 1)) ? '0 : ptr + 1'b1;
		end else begin
			scan_cnt <= scan_cnt - 1'b1;
		end
	end

	always_comb begin
		for (int d = 0; d < disp_pkg::NUM_DIGITS; d++)
			o_seg_enb[d] = (ptr != ptr_t'(d));	// active low
	end

	assign o_seg = i_digit_seg[ptr];

	a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

//--- hw/time_ctrl_if.sv
`timescale 1ns/1ps

interface time_ctrl_if;

	logic              sec_tick;	// withheld in setup mode
	logic              edit_time;
	logic              edit_alarm;
	clock_pkg::pos_e   pos;
	clock_pkg::mode_e  mode;

	modport ctrl (
		output sec_tick, edit_time, edit_alarm, pos, mode
	);

	modport keeper (
		input sec_tick, edit_time, edit_alarm, pos, mode
	);

endinterface

//--- hw/time_keeper.sv
`timescale 1ns/1ps

module time_keeper (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_alarm_en,
	time_ctrl_if.keeper      i_tc,
	output clock_pkg::hms_t  o_disp,
	output logic             o_alarm
);

	clock_pkg::hms_t clk_time;
	clock_pkg::hms_t alm_time;

	// count up, reload at max
	function automatic logic [clock_pkg::FIELD_W-1:0] step(
		input logic [clock_pkg::FIELD_W-1:0] val,
		input logic [clock_pkg::FIELD_W-1:0] max
	);
		return (val >= max) ? '0 : val + 1'b1;
	endfunction

	// bump one field only, no carry
	function automatic clock_pkg::hms_t edit(
		input clock_pkg::hms_t t,
		input clock_pkg::pos_e p
	);
		clock_pkg::hms_t r;
		r = t;
		case (p)
			clock_pkg::POS_SEC: r.sec = step(t.sec, clock_pkg::SEC_MAX);
			clock_pkg::POS_MIN: r.min = step(t.min, clock_pkg::MIN_MAX);
			default:            r.hr  = step(t.hr, clock_pkg::HR_MAX);
		endcase
		return r;
	endfunction

	// ------------------------------
	// clock and alarm time
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_time <= '0;
		end else if (i_tc.sec_tick) begin
			clk_time.sec <= step(clk_time.sec, clock_pkg::SEC_MAX);
			if (clk_time.sec >= clock_pkg::SEC_MAX) begin
				clk_time.min <= step(clk_time.min, clock_pkg::MIN_MAX);
				if (clk_time.min >= clock_pkg::MIN_MAX)
					clk_time.hr <= step(clk_time.hr, clock_pkg::HR_MAX);
			end
		end else if (i_tc.edit_time) begin
			clk_time <= edit(clk_time, i_tc.pos);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alm_time <= '0;
		else if (i_tc.edit_alarm)
			alm_time <= edit(alm_time, i_tc.pos);
	end

	assign o_disp = (i_tc.mode == clock_pkg::MODE_ALARM) ? alm_time : clk_time;

	// latched until enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= ((clk_time == alm_time) | o_alarm) & i_alarm_en;
	end

	a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
		clk_time.sec <= clock_pkg::SEC_MAX && clk_time.min <= clock_pkg::MIN_MAX &&
		clk_time.hr <= clock_pkg::HR_MAX && alm_time.sec <= clock_pkg::SEC_MAX &&
		alm_time.min <= clock_pkg::MIN_MAX && alm_time.hr <= clock_pkg::HR_MAX);

endmodule

//--- testbench/tb_clock_top.sv
`timescale 1ns/1ps

module tb_clock_top;

	localparam int BTN_MODE       = 0;
	localparam int BTN_POS        = 1;
	localparam int BTN_INC        = 2;
	localparam int BTN_ALARM      = 3;
	localparam int CHECK_PHASE    = clock_pkg::SEC_DIV * 3 / 4;	// mid second
	localparam int QUIET_CYCLES   = 6 * disp_pkg::SCAN_DIV + 16;
	localparam int TIMEOUT_CYCLES = 80 * clock_pkg::SEC_DIV + 2000;
	localparam logic [3:0] BLANK  = 4'hA;

	logic                            clk;
	logic                            rst_n;
	logic [3:0]                      btns;	// bit order as BTN_*
	disp_pkg::seg_t                  o_seg;
	logic [disp_pkg::NUM_DIGITS-1:0] o_seg_enb;
	logic                            o_alarm;

	int               cyc;
	int               last_btn;
	int               run_cycles = 0;
	logic [3:0]       btn_q;
	logic [3:0]       btn_rise;
	clock_pkg::mode_e exp_mode;
	clock_pkg::pos_e  exp_pos;
	logic             exp_en;
	logic             exp_alarm_out;
	clock_pkg::hms_t  exp_time;
	clock_pkg::hms_t  exp_alm;
	logic [23:0]      exp_digits;
	logic [5:0]       may_blank;
	logic [23:0]      shadow;	// digit d at [4d+3:4d]
	logic [5:0]       visited;
	logic [3:0]       cur_num;
	logic             quiet;
	logic             check_now;
	int               blank_seen [2] = '{0, 0};	// digits 2 and 3
	int               lit_seen   [2] = '{0, 0};
	int               disp_errs  = 0;
	int               alarm_errs = 0;
	int               enb_errs   = 0;
	int               other_errs = 0;

	clock_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btns[BTN_MODE]),
		.i_btn_pos   (btns[BTN_POS]),
		.i_btn_inc   (btns[BTN_INC]),
		.i_btn_alarm (btns[BTN_ALARM]),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.o_alarm     (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) run_cycles <= run_cycles + 1;

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic clock_pkg::hms_t add_secs(input clock_pkg::hms_t t, input int n);
		int              total;
		clock_pkg::hms_t r;
		total = (t.hr * 3600 + t.min * 60 + t.sec + n) % 86400;
		r.hr  = 6'(total / 3600);
		r.min = 6'((total / 60) % 60);
		r.sec = 6'(total % 60);
		return r;
	endfunction

	function automatic clock_pkg::hms_t bump(input clock_pkg::hms_t t, input clock_pkg::pos_e p);
		clock_pkg::hms_t r;
		r = t;
		case (p)
			clock_pkg::POS_SEC: r.sec = 6'((t.sec + 1) % 60);
			clock_pkg::POS_MIN: r.min = 6'((t.min + 1) % 60);
			default:            r.hr  = 6'((t.hr + 1) % 24);	// no carry on edits
		endcase
		return r;
	endfunction

	function automatic logic [23:0] to_digits(input clock_pkg::hms_t t);
		return {4'(t.hr / 10), 4'(t.hr % 10), 4'(t.min / 10), 4'(t.min % 10),
			4'(t.sec / 10), 4'(t.sec % 10)};
	endfunction

	assign btn_rise = btns & ~btn_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc           <= 0;
			last_btn      <= 0;
			btn_q         <= '0;
			exp_mode      <= clock_pkg::MODE_CLOCK;
			exp_pos       <= clock_pkg::POS_SEC;
			exp_en        <= 1'b0;
			exp_alarm_out <= 1'b0;
			exp_time      <= '0;
			exp_alm       <= '0;
		end else begin
			cyc   <= cyc + 1;
			btn_q <= btns;
			if (btns != '0)
				last_btn <= cyc;
			if (!exp_en)
				exp_alarm_out <= 1'b0;
			else if (exp_time == exp_alm)
				exp_alarm_out <= 1'b1;
			if (cyc % clock_pkg::SEC_DIV == 0 && cyc != 0 && exp_mode != clock_pkg::MODE_SETUP)
				exp_time <= add_secs(exp_time, 1);
			if (btn_rise[BTN_MODE]) begin
				case (exp_mode)
					clock_pkg::MODE_CLOCK: exp_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: exp_mode <= clock_pkg::MODE_ALARM;
					default:               exp_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (btn_rise[BTN_POS]) begin
				case (exp_pos)
					clock_pkg::POS_SEC: exp_pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: exp_pos <= clock_pkg::POS_HR;
					default:            exp_pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (btn_rise[BTN_ALARM])
				exp_en <= !exp_en;
			if (btn_rise[BTN_INC] && exp_mode == clock_pkg::MODE_SETUP)
				exp_time <= bump(exp_time, exp_pos);
			if (btn_rise[BTN_INC] && exp_mode == clock_pkg::MODE_ALARM)
				exp_alm <= bump(exp_alm, exp_pos);
		end
	end

	assign exp_digits = to_digits((exp_mode == clock_pkg::MODE_ALARM) ? exp_alm : exp_time);

	always_comb begin
		may_blank = '0;
		if (exp_mode != clock_pkg::MODE_CLOCK) begin
			case (exp_pos)
				clock_pkg::POS_SEC: may_blank[1:0] = 2'b11;
				clock_pkg::POS_MIN: may_blank[3:2] = 2'b11;
				default:            may_blank[5:4] = 2'b11;
			endcase
		end
	end

	// ------------------------------
	// display reader
	// ------------------------------
	function automatic logic [3:0] seg_to_num(input disp_pkg::seg_t s);
		case (s)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_0011: return 4'd9;
			7'b000_0000: return BLANK;
			default:     return 4'hF;	// not a digit
		endcase
	endfunction

	function automatic bit disp_ok(input logic [23:0] got, input logic [23:0] want,
		input logic [5:0] blink);
		for (int d = 0; d < 6; d++) begin
			if (got[4*d +: 4] != want[4*d +: 4] && !(blink[d] && got[4*d +: 4] == BLANK))
				return 1'b0;
		end
		return 1'b1;
	endfunction

	assign cur_num   = seg_to_num(o_seg);
	assign quiet     = (cyc - last_btn) > QUIET_CYCLES;
	assign check_now = quiet && (cyc % clock_pkg::SEC_DIV == CHECK_PHASE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shadow  <= '1;
			visited <= '0;
		end else begin
			for (int d = 0; d < disp_pkg::NUM_DIGITS; d++) begin
				if (!o_seg_enb[d])
					shadow[4*d +: 4] <= cur_num;
			end
			if (cyc < 6 * disp_pkg::SCAN_DIV)
				visited <= visited | ~o_seg_enb;
			for (int d = 2; d <= 3; d++) begin
				if (!o_seg_enb[d] && quiet && exp_mode == clock_pkg::MODE_SETUP &&
					exp_pos == clock_pkg::POS_MIN) begin
					if (cur_num == BLANK)
						blank_seen[d-2] <= blank_seen[d-2] + 1;
					else if (cur_num == exp_digits[4*d +: 4])
						lit_seen[d-2] <= lit_seen[d-2] + 1;
				end
			end
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~o_seg_enb))
		else begin
			enb_errs++;
			$display("ERROR o_seg_enb: %h has not exactly one low bit", $sampled(o_seg_enb));
		end

	a_display: assert property (@(posedge clk) disable iff (!rst_n)
		check_now |-> disp_ok(shadow, exp_digits, may_blank))
		else begin
			disp_errs++;
			$display("ERROR o_seg: display %h expected %h", $sampled(shadow), $sampled(exp_digits));
		end

	a_alarm: assert property (@(posedge clk) disable iff (!rst_n)
		check_now |-> (o_alarm == exp_alarm_out))
		else begin
			alarm_errs++;
			$display("ERROR o_alarm: got %h expected %h",
				$sampled(o_alarm), $sampled(exp_alarm_out));
		end

	// ------------------------------
	// stimulus
	// ------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic press(input int idx);
		@(negedge clk);
		btns[idx] = 1'b1;
		repeat (3) @(negedge clk);
		btns[idx] = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	// keeps mode changes away from a second boundary
	task automatic press_aligned(input int idx);
		while (cyc % clock_pkg::SEC_DIV != 10)
			@(negedge clk);
		press(idx);
	endtask

	task automatic wait_secs(input int n);
		repeat (n * clock_pkg::SEC_DIV) @(negedge clk);
	endtask

	initial begin
		logic [31:0]     rnd;
		int              n_inc;
		int              wait_cnt;
		clock_pkg::hms_t tgt;
		rnd   = 32'h8511_d364;
		rst_n = 1'b0;
		btns  = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		repeat (6 * disp_pkg::SCAN_DIV) @(negedge clk);
		a_visited: assert (visited == 6'h3f)
			else begin
				other_errs++;
				$display("scan did not visit all six digits right after reset");
			end
		wait_secs(65);	// covers the minute carry

		press_aligned(BTN_MODE);	// setup
		wait_secs(2);
		press(BTN_POS);
		rnd   = lcg_next(rnd);
		n_inc = int'(rnd[23:16] % 5) + 1;
		repeat (n_inc) press(BTN_INC);
		wait_secs(2);
		a_blink: assert (blank_seen[0] != 0 && blank_seen[1] != 0 &&
			lit_seen[0] != 0 && lit_seen[1] != 0)
			else begin
				other_errs++;
				$display("minute digits did not blink in setup mode");
			end
		press_aligned(BTN_MODE);
		press_aligned(BTN_MODE);	// back to clock
		wait_secs(2);

		press_aligned(BTN_MODE);
		press_aligned(BTN_MODE);	// alarm setup, position still on minutes
		tgt = add_secs(exp_time, 3);
		while (exp_alm.min != tgt.min) begin
			press(BTN_INC);
			tgt = add_secs(exp_time, 3);
		end
		press(BTN_POS);
		press(BTN_POS);
		tgt = add_secs(exp_time, 3);
		while (exp_alm.sec != tgt.sec) begin
			press(BTN_INC);
			tgt = add_secs(exp_time, 3);
		end
		press_aligned(BTN_ALARM);	// enable
		wait_cnt = 0;
		while (!o_alarm && wait_cnt < 5 * clock_pkg::SEC_DIV) begin
			@(negedge clk);
			wait_cnt++;
		end
		a_alarm_rose: assert (o_alarm)
			else begin
				other_errs++;
				$display("alarm output never rose after the alarm time was reached");
			end
		wait_secs(2);
		press_aligned(BTN_ALARM);	// disable
		wait_secs(1);

		$display("error counts: display %0d, alarm %0d, enable %0d, other %0d",
			disp_errs, alarm_errs, enb_errs, other_errs);
		if (disp_errs + alarm_errs + enb_errs + other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		while (run_cycles < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
